/* src/cluster_periph_pkg.sv */
// Shared constants and types for the cluster peripheral slice.
// Covers bus widths, the slot and register maps and the event source encoding.
// Modules take it by a wildcard import in the body.

package cluster_periph_pkg;

  // Peripheral bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned ID_W   = 4;

  //**********************************************************
  // Address map
  //**********************************************************

  // Slot field sits at add[SLOT_LSB+1:SLOT_LSB]
  localparam int unsigned SLOT_LSB = 10;

  typedef enum logic [1:0] {
    SLOT_TIMER  = 2'd0,
    SLOT_EU     = 2'd1,
    SLOT_ICACHE = 2'd2,
    SLOT_NONE   = 2'd3
  } periph_slot_e;

  // Word offset inside a slot
  localparam int unsigned REG_LSB = 2;

  localparam logic [1:0] TMR_COUNT = 2'd0;
  localparam logic [1:0] TMR_CMP   = 2'd1;
  localparam logic [1:0] TMR_CTRL  = 2'd2;

  localparam logic [1:0] EU_MASK   = 2'd0;
  localparam logic [1:0] EU_STATUS = 2'd1;

  localparam logic [DATA_W-1:0] UNMAPPED_RDATA = 32'hDEADB33F;

  //**********************************************************
  // Events
  //**********************************************************

  // Lower value wins arbitration
  typedef enum logic [1:0] {
    EVT_MBOX  = 2'd0,
    EVT_TIMER = 2'd1,
    EVT_DMA   = 2'd2,
    EVT_SOC   = 2'd3
  } evt_src_e;

  localparam int unsigned NB_EVT   = 4;
  localparam int unsigned IRQ_BASE = 16;

endpackage

/* src/periph_bus_if.sv */
// Request/response link between the bus decoder and one target.
// The decoder takes the master modport, the target the slave modport.
`timescale 1ns/1ps

interface periph_bus_if;
  import cluster_periph_pkg::*;

  // Request side, one-cycle strobe, wen high means read
  logic              req;
  logic [ADDR_W-1:0] add;
  logic              wen;
  logic [DATA_W-1:0] wdata;
  logic [ID_W-1:0]   id;

  // Response one cycle after req
  logic              r_valid;
  logic [DATA_W-1:0] r_rdata;
  logic [ID_W-1:0]   r_id;

  modport master (
    output req, add, wen, wdata, id,
    input  r_valid, r_rdata, r_id
  );

  modport slave (
    input  req, add, wen, wdata, id,
    output r_valid, r_rdata, r_id
  );

endinterface

/* src/periph_bus_decoder.sv */
// Routes core peripheral bus requests to the timer and event unit slots.
// The stub icache slot and the unmapped slot are answered here.
// Responses from all sides are merged onto the top-level response port.
`timescale 1ns/1ps

module periph_bus_decoder (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                req_i,
  input  logic [cluster_periph_pkg::ADDR_W-1:0] add_i,
  input  logic                                wen_i,
  input  logic [cluster_periph_pkg::DATA_W-1:0] wdata_i,
  input  logic [cluster_periph_pkg::ID_W-1:0]   id_i,
  output logic                                gnt_o,
  output logic                                r_valid_o,
  output logic [cluster_periph_pkg::DATA_W-1:0] r_rdata_o,
  output logic [cluster_periph_pkg::ID_W-1:0]   r_id_o,
  periph_bus_if.master                        tmr_bus,
  periph_bus_if.master                        eu_bus
);
  import cluster_periph_pkg::*;

  periph_slot_e      slot;
  logic              stub_sel;
  logic              stub_valid_q;
  logic [ID_W-1:0]   stub_id_q;
  logic [DATA_W-1:0] stub_rdata_q;

  assign slot     = periph_slot_e'(add_i[SLOT_LSB +: 2]);
  assign stub_sel = (slot == SLOT_ICACHE) || (slot == SLOT_NONE);

  // No back-pressure on this bus
  assign gnt_o = 1'b1;

  //**********************************************************
  // Request fan-out
  //**********************************************************
  assign tmr_bus.req   = req_i && (slot == SLOT_TIMER);
  assign tmr_bus.add   = add_i;
  assign tmr_bus.wen   = wen_i;
  assign tmr_bus.wdata = wdata_i;
  assign tmr_bus.id    = id_i;

  assign eu_bus.req    = req_i && (slot == SLOT_EU);
  assign eu_bus.add    = add_i;
  assign eu_bus.wen    = wen_i;
  assign eu_bus.wdata  = wdata_i;
  assign eu_bus.id     = id_i;

  //**********************************************************
  // Stub and unmapped responder
  //**********************************************************
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      stub_valid_q <= 1'b0;
    end else begin
      stub_valid_q <= req_i && stub_sel;
    end
  end

  // Writes are dropped and answered with zero
  always_ff @(posedge clk_i) begin
    stub_id_q    <= id_i;
    stub_rdata_q <= (slot == SLOT_NONE && wen_i) ? UNMAPPED_RDATA : '0;
  end

  // Response return mux
  always_comb begin
    r_valid_o = tmr_bus.r_valid | eu_bus.r_valid | stub_valid_q;
    if (tmr_bus.r_valid) begin
      r_rdata_o = tmr_bus.r_rdata;
      r_id_o    = tmr_bus.r_id;
    end else if (eu_bus.r_valid) begin
      r_rdata_o = eu_bus.r_rdata;
      r_id_o    = eu_bus.r_id;
    end else begin
      r_rdata_o = stub_rdata_q;
      r_id_o    = stub_id_q;
    end
  end

  // Targets never answer in the same cycle
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({tmr_bus.r_valid, eu_bus.r_valid, stub_valid_q}));

endmodule

/* src/periph_timer.sv */
// Free-running compare timer on the peripheral bus.
// Counts on clk_i while CTRL bit 0 is set and emits a one-cycle event
// when the count reaches the compare value, then wraps to zero.
`timescale 1ns/1ps

module periph_timer (
  input  logic        clk_i,
  input  logic        rst_n_i,
  periph_bus_if.slave bus,
  output logic        tmr_evt_o
);
  import cluster_periph_pkg::*;

  logic [DATA_W-1:0] count_q;
  logic [DATA_W-1:0] cmp_q;
  logic              en_q;
  logic              evt_q;
  logic              match;
  logic              wr_en;
  logic [1:0]        reg_sel;
  logic [DATA_W-1:0] rd_word;
  logic              r_valid_q;
  logic [ID_W-1:0]   r_id_q;
  logic [DATA_W-1:0] r_rdata_q;

  assign reg_sel = bus.add[REG_LSB +: 2];
  assign wr_en   = bus.req && !bus.wen;
  assign match   = en_q && (count_q == cmp_q);

  // Register read mux
  always_comb begin
    case (reg_sel)
      TMR_COUNT: rd_word = count_q;
      TMR_CMP:   rd_word = cmp_q;
      TMR_CTRL:  rd_word = {{(DATA_W-1){1'b0}}, en_q};
      default:   rd_word = '0;
    endcase
  end

  // Counter and config registers, a bus write to COUNT wins
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
      cmp_q   <= '0;
      en_q    <= 1'b0;
      evt_q   <= 1'b0;
    end else begin
      evt_q <= match;
      if (wr_en && reg_sel == TMR_COUNT) begin
        count_q <= bus.wdata;
      end else if (match) begin
        count_q <= '0;
      end else if (en_q) begin
        count_q <= count_q + 1'b1;
      end
      if (wr_en && reg_sel == TMR_CMP) begin
        cmp_q <= bus.wdata;
      end
      if (wr_en && reg_sel == TMR_CTRL) begin
        en_q <= bus.wdata[0];
      end
    end
  end

  // Response one cycle after the request
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= bus.req;
    end
  end

  always_ff @(posedge clk_i) begin
    r_id_q    <= bus.id;
    r_rdata_q <= bus.wen ? rd_word : '0;
  end

  assign bus.r_valid = r_valid_q;
  assign bus.r_id    = r_id_q;
  assign bus.r_rdata = r_rdata_q;
  assign tmr_evt_o   = evt_q;

endmodule

/* src/event_collector.sv */
// Collects event strobes from all sources into pending bits.
// Pushes the highest priority pending source into the event FIFO,
// one per cycle, and holds everything while the FIFO is full.
`timescale 1ns/1ps

module event_collector (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          mbox_irq_i,
  input  logic                          tmr_evt_i,
  input  logic                          dma_event_i,
  input  logic                          soc_evt_i,
  input  logic                          full_i,
  output logic                          push_o,
  output cluster_periph_pkg::evt_src_e  push_src_o
);
  import cluster_periph_pkg::*;

  logic [NB_EVT-1:0] evt_in;
  logic [NB_EVT-1:0] pending_q;
  logic [NB_EVT-1:0] clr_mask;

  assign evt_in[EVT_MBOX]  = mbox_irq_i;
  assign evt_in[EVT_TIMER] = tmr_evt_i;
  assign evt_in[EVT_DMA]   = dma_event_i;
  assign evt_in[EVT_SOC]   = soc_evt_i;

  assign push_o = (|pending_q) && !full_i;

  // Lowest index pending source wins
  always_comb begin
    push_src_o = EVT_MBOX;
    for (int i = NB_EVT - 1; i >= 0; i--) begin
      if (pending_q[i]) begin
        push_src_o = evt_src_e'(i[1:0]);
      end
    end
  end

  always_comb begin
    clr_mask = '0;
    if (push_o) begin
      clr_mask[push_src_o] = 1'b1;
    end
  end

  // A new strobe on the bit being pushed sets it again
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q & ~clr_mask) | evt_in;
    end
  end

  // Nothing leaves the pending set while the FIFO is full
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    full_i |=> ($past(pending_q) & ~pending_q) == '0);

endmodule

/* src/event_fifo.sv */
// Circular buffer of event sources between the collector and dispatcher.
// The head entry is visible on pop_src_o before it is popped.
// FIFO_DEPTH must be a power of two, 2 or more.
`timescale 1ns/1ps

module event_fifo #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          push_i,
  input  cluster_periph_pkg::evt_src_e  push_src_i,
  input  logic                          pop_i,
  output cluster_periph_pkg::evt_src_e  pop_src_o,
  output logic                          full_o,
  output logic                          empty_o
);
  import cluster_periph_pkg::*;

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);

  evt_src_e         mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;

  assign full_o    = (count_q == (PTR_W+1)'(FIFO_DEPTH));
  assign empty_o   = (count_q == '0);
  assign pop_src_o = mem[rd_ptr_q];

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q] <= push_src_i;
    end
  end

  // Pointers wrap on their own width
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) push_i |-> !full_o);
  assert property (@(posedge clk_i) disable iff (!rst_n_i) pop_i |-> !empty_o);

endmodule

/* src/irq_dispatcher.sv */
// Pops buffered events and raises the core interrupt.
// Masked sources are dropped; a raised request holds its ID until acknowledge.
// Holds the event unit MASK and STATUS registers on the peripheral bus.
`timescale 1ns/1ps

module irq_dispatcher (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          empty_i,
  input  cluster_periph_pkg::evt_src_e  pop_src_i,
  input  logic                          irq_ack_i,
  periph_bus_if.slave                   bus,
  output logic                          pop_o,
  output logic                          irq_req_o,
  output logic [4:0]                    irq_id_o
);
  import cluster_periph_pkg::*;

  logic [NB_EVT-1:0] mask_q;
  logic              irq_req_q;
  evt_src_e          irq_src_q;
  logic [1:0]        reg_sel;
  logic [DATA_W-1:0] rd_word;
  logic              r_valid_q;
  logic [ID_W-1:0]   r_id_q;
  logic [DATA_W-1:0] r_rdata_q;

  assign reg_sel = bus.add[REG_LSB +: 2];

  // Idle, or freed by the ack in this cycle
  assign pop_o = !empty_i && (!irq_req_q || irq_ack_i);

  always_comb begin
    case (reg_sel)
      EU_MASK:   rd_word = {{(DATA_W-NB_EVT){1'b0}}, mask_q};
      EU_STATUS: rd_word = {{(DATA_W-5){1'b0}}, irq_req_q, 2'b00, irq_src_q};
      default:   rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mask_q    <= '0;
      irq_req_q <= 1'b0;
      irq_src_q <= EVT_MBOX;
    end else begin
      if (bus.req && !bus.wen && reg_sel == EU_MASK) begin
        mask_q <= bus.wdata[NB_EVT-1:0];
      end
      if (irq_ack_i) begin
        irq_req_q <= 1'b0;
      end
      // Masked entries are popped and discarded
      if (pop_o && mask_q[pop_src_i]) begin
        irq_req_q <= 1'b1;
        irq_src_q <= pop_src_i;
      end
    end
  end

  // Bus response
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= bus.req;
    end
  end

  always_ff @(posedge clk_i) begin
    r_id_q    <= bus.id;
    r_rdata_q <= bus.wen ? rd_word : '0;
  end

  assign bus.r_valid = r_valid_q;
  assign bus.r_id    = r_id_q;
  assign bus.r_rdata = r_rdata_q;
  assign irq_req_o   = irq_req_q;
  assign irq_id_o    = 5'(IRQ_BASE) + 5'(irq_src_q);

  // Request and ID hold until the core acknowledges
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    irq_req_o && !irq_ack_i |=> irq_req_o && $stable(irq_id_o));

endmodule

/* src/cluster_periph_top.sv */
// Single-core cluster peripheral slice.
// Peripheral bus in, timer and event unit behind a slot decoder,
// and one interrupt request with ID and acknowledge toward the core.
`timescale 1ns/1ps

module cluster_periph_top #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                req_i,
  input  logic [cluster_periph_pkg::ADDR_W-1:0] add_i,
  input  logic                                wen_i,
  input  logic [cluster_periph_pkg::DATA_W-1:0] wdata_i,
  input  logic [cluster_periph_pkg::ID_W-1:0]   id_i,
  output logic                                gnt_o,
  output logic                                r_valid_o,
  output logic [cluster_periph_pkg::DATA_W-1:0] r_rdata_o,
  output logic [cluster_periph_pkg::ID_W-1:0]   r_id_o,
  input  logic                                mbox_irq_i,
  input  logic                                dma_event_i,
  input  logic                                soc_evt_i,
  input  logic                                irq_ack_i,
  output logic                                irq_req_o,
  output logic [4:0]                          irq_id_o
);
  import cluster_periph_pkg::*;

  logic     tmr_evt;
  logic     push;
  evt_src_e push_src;
  logic     pop;
  evt_src_e pop_src;
  logic     fifo_full;
  logic     fifo_empty;

  periph_bus_if tmr_bus ();
  periph_bus_if eu_bus ();

  //**********************************************************
  // Bus side
  //**********************************************************
  periph_bus_decoder periph_bus_decoder_i (
    .clk_i     ( clk_i     ),
    .rst_n_i   ( rst_n_i   ),
    .req_i     ( req_i     ),
    .add_i     ( add_i     ),
    .wen_i     ( wen_i     ),
    .wdata_i   ( wdata_i   ),
    .id_i      ( id_i      ),
    .gnt_o     ( gnt_o     ),
    .r_valid_o ( r_valid_o ),
    .r_rdata_o ( r_rdata_o ),
    .r_id_o    ( r_id_o    ),
    .tmr_bus   ( tmr_bus   ),
    .eu_bus    ( eu_bus    )
  );

  periph_timer periph_timer_i (
    .clk_i     ( clk_i   ),
    .rst_n_i   ( rst_n_i ),
    .bus       ( tmr_bus ),
    .tmr_evt_o ( tmr_evt )
  );

  //**********************************************************
  // Event path
  //**********************************************************
  event_collector event_collector_i (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .mbox_irq_i  ( mbox_irq_i  ),
    .tmr_evt_i   ( tmr_evt     ),
    .dma_event_i ( dma_event_i ),
    .soc_evt_i   ( soc_evt_i   ),
    .full_i      ( fifo_full   ),
    .push_o      ( push        ),
    .push_src_o  ( push_src    )
  );

  event_fifo #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) event_fifo_i (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .push_i     ( push       ),
    .push_src_i ( push_src   ),
    .pop_i      ( pop        ),
    .pop_src_o  ( pop_src    ),
    .full_o     ( fifo_full  ),
    .empty_o    ( fifo_empty )
  );

  irq_dispatcher irq_dispatcher_i (
    .clk_i     ( clk_i      ),
    .rst_n_i   ( rst_n_i    ),
    .empty_i   ( fifo_empty ),
    .pop_src_i ( pop_src    ),
    .irq_ack_i ( irq_ack_i  ),
    .bus       ( eu_bus     ),
    .pop_o     ( pop        ),
    .irq_req_o ( irq_req_o  ),
    .irq_id_o  ( irq_id_o   )
  );

endmodule

/* dv/cluster_periph_tb.sv */
// Testbench for the cluster peripheral slice.
// Drives the peripheral bus and event strobes of cluster_periph_top,
// checks bus timing, the slot map, timer events, priority and masking.
// Run through the file list in the project root.
`timescale 1ns/1ps

module cluster_periph_tb;
  import cluster_periph_pkg::*;

  localparam int MAX_CYCLES = 2000;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        req;
  logic [31:0] add;
  logic        wen;
  logic [31:0] wdata;
  logic [3:0]  id;
  logic        gnt;
  logic        r_valid_o;
  logic [31:0] r_rdata_o;
  logic [3:0]  r_id_o;
  logic        mbox_irq;
  logic        dma_event;
  logic        soc_evt;
  logic        irq_ack;
  logic        irq_req_o;
  logic [4:0]  irq_id_o;

  int          cycle_cnt = 0;
  int          bus_err_cnt = 0;
  int          irq_err_cnt = 0;
  int          chk_err_cnt = 0;
  int          pass_cnt;
  int          fail_cnt;
  int          errs_before;
  string       cur_test = "reset";
  logic [3:0]  next_id;
  logic [31:0] rng_state;
  logic [31:0] rand_val;

  always #4 clk = ~clk;

  cluster_periph_top #(
    .FIFO_DEPTH ( 4 )
  ) cluster_periph_top_i (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .req_i       ( req       ),
    .add_i       ( add       ),
    .wen_i       ( wen       ),
    .wdata_i     ( wdata     ),
    .id_i        ( id        ),
    .gnt_o       ( gnt       ),
    .r_valid_o   ( r_valid_o ),
    .r_rdata_o   ( r_rdata_o ),
    .r_id_o      ( r_id_o    ),
    .mbox_irq_i  ( mbox_irq  ),
    .dma_event_i ( dma_event ),
    .soc_evt_i   ( soc_evt   ),
    .irq_ack_i   ( irq_ack   ),
    .irq_req_o   ( irq_req_o ),
    .irq_id_o    ( irq_id_o  )
  );

  //************************************************************
  // Protocol checks running through every test
  //************************************************************
  // Exactly one response per request, one cycle later
  assert property (@(posedge clk) disable iff (!rst_n) r_valid_o == $past(req))
    else begin
      $display("CHECK FAILED %s r_valid_o expected %0b actual %0b",
               cur_test, !r_valid_o, r_valid_o);
      bus_err_cnt++;
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    irq_req_o && !irq_ack |=> irq_req_o && $stable(irq_id_o))
    else begin
      $display("%s: irq_req_o dropped or irq_id_o changed before acknowledge", cur_test);
      irq_err_cnt++;
    end

  // Run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("Timeout: run went past %0d cycles", MAX_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  //************************************************************
  // Helpers
  //************************************************************
  function automatic logic [31:0] lcg_next(logic [31:0] state);
    lcg_next = state * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [31:0] addr_of(periph_slot_e slot, logic [1:0] reg_off);
    addr_of = '0;
    addr_of[SLOT_LSB +: 2] = slot;
    addr_of[REG_LSB +: 2] = reg_off;
  endfunction

  function automatic int total_errs();
    total_errs = bus_err_cnt + irq_err_cnt + chk_err_cnt;
  endfunction

  task automatic check_value(string label, logic [31:0] exp, logic [31:0] act);
    assert (exp == act)
      else begin
        $display("CHECK FAILED %s %s expected %h actual %h", cur_test, label, exp, act);
        chk_err_cnt++;
      end
  endtask

  // One-cycle request, response sampled mid-cycle
  task automatic bus_access(input logic [31:0] addr, input logic is_read,
                            input logic [31:0] data, output logic [31:0] rdata);
    logic [3:0] tid;
    tid = next_id;
    next_id = next_id + 4'd1;
    @(posedge clk);
    #1;
    req = 1'b1;
    add = addr;
    wen = is_read;
    wdata = data;
    id = tid;
    @(posedge clk);
    #1;
    req = 1'b0;
    @(negedge clk);
    check_value("r_id_o", 32'(tid), 32'(r_id_o));
    if (!is_read) begin
      check_value("write r_rdata_o", 32'd0, r_rdata_o);
    end
    rdata = r_rdata_o;
  endtask

  task automatic bus_write(logic [31:0] addr, logic [31:0] data);
    logic [31:0] unused_rdata;
    bus_access(addr, 1'b0, data, unused_rdata);
  endtask

  task automatic read_expect(string label, logic [31:0] addr, logic [31:0] exp);
    logic [31:0] rdata;
    bus_access(addr, 1'b1, 32'd0, rdata);
    check_value(label, exp, rdata);
  endtask

  task automatic pulse_events(logic mbox, logic dma, logic soc);
    @(posedge clk);
    #1;
    mbox_irq = mbox;
    dma_event = dma;
    soc_evt = soc;
    @(posedge clk);
    #1;
    mbox_irq = 1'b0;
    dma_event = 1'b0;
    soc_evt = 1'b0;
  endtask

  task automatic wait_irq(int limit, output logic found);
    found = 1'b0;
    for (int i = 0; i < limit; i++) begin
      @(negedge clk);
      if (irq_req_o) begin
        found = 1'b1;
        break;
      end
    end
  endtask

  task automatic expect_irq(int limit, logic [4:0] exp_id);
    logic found;
    wait_irq(limit, found);
    if (!found) begin
      $display("%s: no interrupt within %0d cycles", cur_test, limit);
      chk_err_cnt++;
    end else begin
      check_value("irq_id_o", 32'(exp_id), 32'(irq_id_o));
    end
  endtask

  task automatic ack_irq();
    @(posedge clk);
    #1;
    irq_ack = 1'b1;
    @(posedge clk);
    #1;
    irq_ack = 1'b0;
  endtask

  task automatic start_test(string name);
    cur_test = name;
    errs_before = total_errs();
  endtask

  task automatic end_test();
    if (total_errs() == errs_before) begin
      pass_cnt++;
      $display("test %s: ok", cur_test);
    end else begin
      fail_cnt++;
      $display("test %s: failed with %0d errors", cur_test, total_errs() - errs_before);
    end
  endtask

  //************************************************************
  // Stimulus
  //************************************************************
  initial begin
    logic found;
    rst_n = 1'b0;
    req = 1'b0;
    add = '0;
    wen = 1'b1;
    wdata = '0;
    id = '0;
    mbox_irq = 1'b0;
    dma_event = 1'b0;
    soc_evt = 1'b0;
    irq_ack = 1'b0;
    next_id = 4'd0;
    rng_state = 32'd15;
    pass_cnt = 0;
    fail_cnt = 0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    start_test("reset_bus");
    @(negedge clk);
    check_value("irq_req_o", 32'd0, 32'(irq_req_o));
    check_value("r_valid_o", 32'd0, 32'(r_valid_o));
    check_value("gnt_o", 32'd1, 32'(gnt));
    read_expect("TMR_CTRL", addr_of(SLOT_TIMER, TMR_CTRL), 32'd0);
    read_expect("EU_MASK", addr_of(SLOT_EU, EU_MASK), 32'd0);
    read_expect("EU_STATUS", addr_of(SLOT_EU, EU_STATUS), 32'd0);
    end_test();

    start_test("slot_map");
    rng_state = lcg_next(rng_state);
    rand_val = rng_state;
    bus_write(addr_of(SLOT_TIMER, TMR_CMP), rand_val);
    read_expect("TMR_CMP", addr_of(SLOT_TIMER, TMR_CMP), rand_val);
    // Only the four source enables exist in the mask
    rng_state = lcg_next(rng_state);
    rand_val = rng_state & 32'hF;
    bus_write(addr_of(SLOT_EU, EU_MASK), rand_val);
    read_expect("EU_MASK", addr_of(SLOT_EU, EU_MASK), rand_val);
    bus_write(addr_of(SLOT_ICACHE, 2'd0), 32'h1234_5678);
    read_expect("icache stub", addr_of(SLOT_ICACHE, 2'd0), 32'd0);
    read_expect("unmapped", addr_of(SLOT_NONE, 2'd1), 32'hDEAD_B33F);
    end_test();

    start_test("timer_event");
    bus_write(addr_of(SLOT_EU, EU_MASK), 32'hF);
    bus_write(addr_of(SLOT_TIMER, TMR_CMP), 32'd20);
    bus_write(addr_of(SLOT_TIMER, TMR_CTRL), 32'd1);
    expect_irq(30, 5'd17);
    // Stop the timer before it wraps around again
    bus_write(addr_of(SLOT_TIMER, TMR_CTRL), 32'd0);
    ack_irq();
    @(negedge clk);
    check_value("irq_req_o after ack", 32'd0, 32'(irq_req_o));
    end_test();

    start_test("priority");
    pulse_events(1'b1, 1'b1, 1'b0);
    expect_irq(20, 5'd16);
    ack_irq();
    expect_irq(20, 5'd18);
    ack_irq();
    @(negedge clk);
    check_value("irq_req_o after ack", 32'd0, 32'(irq_req_o));
    end_test();

    start_test("masking");
    bus_write(addr_of(SLOT_EU, EU_MASK), 32'h7);
    pulse_events(1'b0, 1'b0, 1'b1);
    wait_irq(20, found);
    check_value("irq_req_o for masked soc", 32'd0, 32'(found));
    pulse_events(1'b0, 1'b1, 1'b0);
    expect_irq(20, 5'd18);
    ack_irq();
    end_test();

    $display("tests passed %0d failed %0d, check errors %0d",
             pass_cnt, fail_cnt, total_errs());
    if (fail_cnt == 0 && total_errs() == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* cluster_periph_top.f */
src/cluster_periph_pkg.sv
src/periph_bus_if.sv
src/periph_bus_decoder.sv
src/periph_timer.sv
src/event_collector.sv
src/event_fifo.sv
src/irq_dispatcher.sv
src/cluster_periph_top.sv
dv/cluster_periph_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the cluster peripheral testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Mdir obj_dir \
  --top-module cluster_periph_tb -f cluster_periph_top.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vcluster_periph_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
  exit 1
fi
exit 0
